//--- hw/analog_pkg.sv
////////////////////
// Analog front end shared definitions
// Sample widths, calibration constants and stream types
////////////////////

package analog_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Two channels, ADC and DAC alike
  localparam int unsigned CHN_NUM = 2;
  // Converter sample width
  localparam int unsigned SMP_W = 14;
  // Calibration gain width
  localparam int unsigned GAIN_W = 16;
  // Gain of 0x4000 is unity
  localparam int unsigned GAIN_SHIFT = 14;
  // Full product of sample and gain
  localparam int unsigned PROD_W = SMP_W + GAIN_W;
  // Shifted product plus offset, one guard bit
  localparam int unsigned SUM_W = PROD_W - GAIN_SHIFT + 1;

  ////////////////////
  // Types
  ////////////////////

  // Two's complement sample
  typedef logic signed [SMP_W-1:0] sample_t;
  // Converter code, bits 15..2 of the 16-bit word
  typedef logic [SMP_W-1:0] raw_t;

  typedef sample_t [CHN_NUM-1:0] chan_smp_t;
  typedef raw_t [CHN_NUM-1:0] chan_raw_t;

  // Per channel linear calibration
  typedef struct packed {
    logic signed [GAIN_W-1:0] gain;
    sample_t                  offset;
  } calib_t;

  typedef calib_t [CHN_NUM-1:0] chan_calib_t;

  // Quasi-static front end configuration
  typedef struct packed {
    logic        digital_loop;
    chan_calib_t adc_cal;
    chan_calib_t dac_cal;
  } analog_cfg_t;

  ////////////////////
  // Constants
  ////////////////////

  // Saturation limits
  localparam sample_t SMP_MAX = sample_t'(2 ** (SMP_W - 1) - 1);
  localparam sample_t SMP_MIN = sample_t'(-(2 ** (SMP_W - 1)));
  // Negative slope code for zero
  localparam raw_t RAW_ZERO = raw_t'(2 ** (SMP_W - 1) - 1);

  // Offset binary with negative slope <-> two's complement
  // Same rule both ways: keep MSB, invert the rest
  function automatic logic [SMP_W-1:0] code_flip(input logic [SMP_W-1:0] word);
    return {word[SMP_W-1], ~word[SMP_W-2:0]};
  endfunction

endpackage

//--- hw/adc_capture.sv
////////////////////
// ADC capture
// Registers raw ADC codes, converts to signed, loopback mux
////////////////////

`timescale 1ns/1ps

module adc_capture (
  // Clock and reset
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // Raw ADC codes from the pins
  input  analog_pkg::chan_raw_t adc_dat_i,
  // Calibrated DAC samples for loopback
  input  analog_pkg::chan_smp_t loop_smp_i,
  input  logic                  digital_loop_i,
  // Captured sample pair
  output analog_pkg::chan_smp_t smp_o
);

  import analog_pkg::*;

  // Converted ADC samples, one per channel
  chan_smp_t adc_smp;

  ////////////////////
  // Input register
  ////////////////////

  // Conversion folded into the IO register
  // Low two converter bits already dropped at the port
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_smp <= '0;
    end else begin
      for (int i = 0; i < CHN_NUM; i++) begin
        adc_smp[i] <= sample_t'(code_flip(adc_dat_i[i]));
      end
    end
  end

  ////////////////////
  // Loopback
  ////////////////////

  // Mux sits after the register, so loopback adds no cycle
  // Both channels switch together
  assign smp_o = digital_loop_i ? loop_smp_i : adc_smp;

endmodule

//--- hw/linear_calib.sv
////////////////////
// Linear calibration
// Gain multiply, shift, offset add and saturation, 2 cycles
////////////////////

`timescale 1ns/1ps

module linear_calib (
  // Clock and reset
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // Sample pair in
  input  analog_pkg::chan_smp_t   smp_i,
  // Gain and offset per channel
  input  analog_pkg::chan_calib_t cal_i,
  // Calibrated pair out
  output analog_pkg::chan_smp_t   smp_o
);

  import analog_pkg::*;

  // Stage one products
  logic signed [PROD_W-1:0] prod_q [CHN_NUM];
  // Shifted product plus offset, before saturation
  logic signed [SUM_W-1:0]  sum_w  [CHN_NUM];
  // Saturated result
  chan_smp_t                sat_w;
  // Stage two register
  chan_smp_t                smp_q;

  ////////////////////
  // Stage one
  ////////////////////

  // Full width signed product, nothing lost yet
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < CHN_NUM; i++) begin
        prod_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < CHN_NUM; i++) begin
        prod_q[i] <= sample_t'(smp_i[i]) * cal_i[i].gain;
      end
    end
  end

  ////////////////////
  // Stage two
  ////////////////////

  // Arithmetic shift drops the gain fraction
  // Offset sampled here, at the stage it is added
  always_comb begin
    for (int i = 0; i < CHN_NUM; i++) begin
      sum_w[i] = SUM_W'(prod_q[i] >>> GAIN_SHIFT) + SUM_W'(cal_i[i].offset);
      // Clamp to the 14-bit range
      if (sum_w[i] > SMP_MAX) begin
        sat_w[i] = SMP_MAX;
      end else if (sum_w[i] < SMP_MIN) begin
        sat_w[i] = SMP_MIN;
      end else begin
        sat_w[i] = sample_t'(sum_w[i]);
      end
    end
  end

  // Output register, zero after reset
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_q <= '0;
    end else begin
      smp_q <= sat_w;
    end
  end

  assign smp_o = smp_q;

endmodule

//--- hw/dac_format.sv
////////////////////
// DAC format
// Signed samples to negative slope DAC code, registered
////////////////////

`timescale 1ns/1ps

module dac_format (
  // Clock and reset
  input  logic                  adc_clk,
  input  logic                  top_rst,
  // Calibrated sample pair
  input  analog_pkg::chan_smp_t smp_i,
  // DAC codes, one per channel
  output analog_pkg::chan_raw_t dac_dat_o
);

  import analog_pkg::*;

  // Output register, feeds the pins directly
  chan_raw_t dac_q;

  // Reset parks the DAC at mid scale, which is zero volts
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_q <= {CHN_NUM{RAW_ZERO}};
    end else begin
      // Same bit flip as on the ADC side
      for (int i = 0; i < CHN_NUM; i++) begin
        dac_q[i] <= raw_t'(code_flip(smp_i[i]));
      end
    end
  end

  // Channels leave as one packed pair
  assign dac_dat_o = dac_q;

endmodule

//--- hw/analog_top.sv
////////////////////
// Analog front end top
// ADC capture and calibration, DAC calibration and formatting
////////////////////

`timescale 1ns/1ps

module analog_top (
  // Clock and reset
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // ADC pins
  input  analog_pkg::chan_raw_t   adc_dat_i,
  // Generator samples toward the DAC
  input  analog_pkg::chan_smp_t   gen_dat_i,
  // Calibration and loopback settings
  input  analog_pkg::analog_cfg_t cfg_i,
  // Calibrated ADC samples
  output analog_pkg::chan_smp_t   adc_cal_o,
  // DAC pins
  output analog_pkg::chan_raw_t   dac_dat_o
);

  import analog_pkg::*;

  // Configuration fields
  logic        digital_loop;
  chan_calib_t adc_cal;
  chan_calib_t dac_cal;

  // Captured ADC pair, or looped back DAC pair
  chan_smp_t   adc_smp;
  // Calibrated generator pair
  chan_smp_t   dac_smp;

  assign digital_loop = cfg_i.digital_loop;
  assign adc_cal      = cfg_i.adc_cal;
  assign dac_cal      = cfg_i.dac_cal;

  ////////////////////
  // ADC path
  ////////////////////

  // 1 cycle capture then 2 cycle calibration
  adc_capture adc_capture_i (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .adc_dat_i      (adc_dat_i),
    .loop_smp_i     (dac_smp),
    .digital_loop_i (digital_loop),
    .smp_o          (adc_smp)
  );

  linear_calib linear_adc (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (adc_smp),
    .cal_i   (adc_cal),
    .smp_o   (adc_cal_o)
  );

  ////////////////////
  // DAC path
  ////////////////////

  // Calibrated output also feeds the loopback mux
  linear_calib linear_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .smp_i   (gen_dat_i),
    .cal_i   (dac_cal),
    .smp_o   (dac_smp)
  );

  dac_format dac_format_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .smp_i     (dac_smp),
    .dac_dat_o (dac_dat_o)
  );

endmodule

//--- tb/analog_assert.sv
////////////////////
// Analog front end assertions
// Reset values and loopback latency
////////////////////

`timescale 1ns/1ps

module analog_assert (
  input logic                    adc_clk,
  input logic                    top_rst,
  input analog_pkg::chan_smp_t   gen_dat_i,
  input analog_pkg::analog_cfg_t cfg_i,
  input analog_pkg::chan_smp_t   adc_cal_i,
  input analog_pkg::chan_raw_t   dac_dat_i
);

  import analog_pkg::*;

  // Zero code on both DAC channels
  localparam chan_raw_t DAC_IDLE = {CHN_NUM{14'h1FFF}};

  // Edges over which cfg_i has not changed
  logic [2:0]  stable_cnt;
  analog_cfg_t cfg_q;
  // Failed properties so far
  int unsigned fail_cnt = 0;

  // Integer model of multiply, floor shift, offset add and clamp
  function automatic sample_t calib_model(input sample_t smp, input calib_t cal);
    int acc;
    acc = ((int'(smp) * int'(cal.gain)) >>> GAIN_SHIFT) + int'(cal.offset);
    if (acc > 8191) begin
      acc = 8191;
    end else if (acc < -8192) begin
      acc = -8192;
    end
    return sample_t'(acc);
  endfunction

  // DAC calibration then ADC calibration on each channel
  function automatic chan_smp_t loop_model(input chan_smp_t gen, input analog_cfg_t cfg);
    chan_smp_t res;
    for (int i = 0; i < CHN_NUM; i++) begin
      res[i] = calib_model(calib_model(gen[i], cfg.dac_cal[i]), cfg.adc_cal[i]);
    end
    return res;
  endfunction

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      stable_cnt <= '0;
      cfg_q      <= '0;
    end else begin
      cfg_q <= cfg_i;
      if (cfg_i != cfg_q) begin
        stable_cnt <= '0;
      end else if (stable_cnt != 3'd7) begin
        stable_cnt <= stable_cnt + 3'd1;
      end
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  adc_reset_a : assert property (@(posedge adc_clk) top_rst |-> adc_cal_i == '0)
    else begin
      fail_cnt++;
      $error("adc_cal_o left zero while reset was high");
    end

  dac_reset_a : assert property (@(posedge adc_clk) top_rst |-> dac_dat_i == DAC_IDLE)
    else begin
      fail_cnt++;
      $error("dac_dat_o left the zero code while reset was high");
    end

  // Config held over the whole 4 cycle loop path
  loop_latency_a : assert property (@(posedge adc_clk) disable iff (top_rst)
    (cfg_i.digital_loop && cfg_i == cfg_q && stable_cnt >= 3'd3)
      |-> adc_cal_i == loop_model($past(gen_dat_i, 4), cfg_i))
    else begin
      fail_cnt++;
      $error("adc_cal_o does not follow gen_dat_i 4 cycles later in loopback");
    end

endmodule

bind analog_top analog_assert analog_assert_i (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .gen_dat_i (gen_dat_i),
  .cfg_i     (cfg_i),
  .adc_cal_i (adc_cal_o),
  .dac_dat_i (dac_dat_o)
);

//--- tb/analog_tb.sv
////////////////////
// Analog front end testbench
// Golden vectors, hold and streaming modes
////////////////////

`timescale 1ns/1ps

module analog_tb;

  import analog_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  // Longer than the loopback latency
  localparam int HOLD_CYCLES = 6;
  // Input to output latency of both paths
  localparam int STREAM_LAT = 3;
  localparam int NVEC = 15;
  // Eight cycles per vector covers the hold mode
  localparam int WATCHDOG_CYCLES = NVEC * 8 + RST_CYCLES;
  // Word offsets inside one golden vector
  localparam int VEC_W = 18;
  localparam int F_MODE = 0;
  localparam int F_LOOP = 1;
  localparam int F_ADC_CAL = 2;
  localparam int F_DAC_CAL = 6;
  localparam int F_ADC = 10;
  localparam int F_GEN = 12;
  localparam int F_EXP_ADC = 14;
  localparam int F_EXP_DAC = 16;
  // Zero code on both DAC channels
  localparam chan_raw_t DAC_IDLE = {CHN_NUM{14'h1FFF}};

  logic        adc_clk;
  logic        top_rst;
  chan_raw_t   adc_dat;
  chan_smp_t   gen_dat;
  analog_cfg_t cfg;
  chan_smp_t   adc_cal;
  chan_raw_t   dac_dat;
  // Top nibble F marks a golden word never loaded
  logic [15:0] golden_mem [NVEC*VEC_W];

  ////////////////////
  // DUT and clock
  ////////////////////

  analog_top analog_top_i (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat),
    .gen_dat_i (gen_dat),
    .cfg_i     (cfg),
    .adc_cal_o (adc_cal),
    .dac_dat_o (dac_dat)
  );

  initial begin
    adc_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  // Calibrated sample pair
  task automatic compare_smp(input string name, input string ctx, input chan_smp_t got,
                             input chan_smp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: got 0x%h expected 0x%h", name, ctx, got, exp));
    end
  endtask

  // DAC code pair
  task automatic compare_raw(input string name, input string ctx, input chan_raw_t got,
                             input chan_raw_t exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s %s: got 0x%h expected 0x%h", name, ctx, got, exp));
    end
  endtask

  ////////////////////
  // Vectors
  ////////////////////

  function automatic int vec_mode(input int v);
    return int'(golden_mem[v * VEC_W + F_MODE]);
  endfunction

  // Unpack one vector onto the DUT inputs
  task automatic drive_vector(input int v);
    int          b;
    analog_cfg_t cfg_v;
    chan_raw_t   adc_v;
    chan_smp_t   gen_v;
    b = v * VEC_W;
    cfg_v.digital_loop = golden_mem[b + F_LOOP][0];
    for (int i = 0; i < CHN_NUM; i++) begin
      cfg_v.adc_cal[i].gain   = golden_mem[b + F_ADC_CAL + 2 * i];
      cfg_v.adc_cal[i].offset = golden_mem[b + F_ADC_CAL + 2 * i + 1][SMP_W-1:0];
      cfg_v.dac_cal[i].gain   = golden_mem[b + F_DAC_CAL + 2 * i];
      cfg_v.dac_cal[i].offset = golden_mem[b + F_DAC_CAL + 2 * i + 1][SMP_W-1:0];
      adc_v[i] = golden_mem[b + F_ADC + i][SMP_W-1:0];
      gen_v[i] = golden_mem[b + F_GEN + i][SMP_W-1:0];
    end
    cfg     <= cfg_v;
    adc_dat <= adc_v;
    gen_dat <= gen_v;
  endtask

  // Expected outputs straight from the golden file
  task automatic check_vector(input int v);
    int        b;
    chan_smp_t exp_adc;
    chan_raw_t exp_dac;
    b = v * VEC_W;
    for (int i = 0; i < CHN_NUM; i++) begin
      exp_adc[i] = golden_mem[b + F_EXP_ADC + i][SMP_W-1:0];
      exp_dac[i] = golden_mem[b + F_EXP_DAC + i][SMP_W-1:0];
    end
    compare_smp("adc_cal_o", $sformatf("vector %0d", v), adc_cal, exp_adc);
    compare_raw("dac_dat_o", $sformatf("vector %0d", v), dac_dat, exp_dac);
  endtask

  // Sampled at the falling edge, outputs settled
  task automatic hold_vector(input int v);
    @(posedge adc_clk);
    drive_vector(v);
    repeat (HOLD_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    check_vector(v);
  endtask

  // Each new pair is checked STREAM_LAT edges after it is driven
  task automatic stream_run(input int first, input int last);
    int n;
    n = last - first;
    for (int c = 0; c < n + STREAM_LAT; c++) begin
      @(posedge adc_clk);
      if (c < n) begin
        drive_vector(first + c);
      end
      @(negedge adc_clk);
      if (c >= STREAM_LAT) begin
        check_vector(first + c - STREAM_LAT);
      end
    end
  endtask

  ////////////////////
  // Watchdog
  ////////////////////

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Timeout: the vectors did not finish within the watchdog time");
  end

  // Any failed property of the bound checker ends the run
  always @(analog_top_i.analog_assert_i.fail_cnt) begin
    if (analog_top_i.analog_assert_i.fail_cnt != 0) begin
      abort_run("A bound assertion on the DUT outputs failed");
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    int v;
    int run_end;
    top_rst = 1'b1;
    adc_dat = '0;
    gen_dat = '0;
    cfg     = '0;
    for (int a = 0; a < NVEC * VEC_W; a++) begin
      golden_mem[a] = 16'hF000 | 16'(a);
    end
    $readmemh("tb/analog_golden.txt", golden_mem);
    for (int a = 0; a < NVEC * VEC_W; a++) begin
      if (golden_mem[a][15:12] == 4'hF) begin
        abort_run("The golden file is missing or holds fewer vectors than expected");
      end
    end
    repeat (RST_CYCLES) @(posedge adc_clk);
    top_rst <= 1'b0;
    @(negedge adc_clk);
    compare_smp("adc_cal_o", "after reset", adc_cal, '0);
    compare_raw("dac_dat_o", "after reset", dac_dat, DAC_IDLE);
    v = 0;
    while (v < NVEC) begin
      if (vec_mode(v) == 0) begin
        hold_vector(v);
        v++;
      end else begin
        // Group consecutive streaming vectors into one run
        run_end = v;
        while (run_end < NVEC && vec_mode(run_end) == 1) begin
          run_end++;
        end
        stream_run(v, run_end);
        v = run_end;
      end
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- sim.f
hw/analog_pkg.sv
hw/adc_capture.sv
hw/linear_calib.sv
hw/dac_format.sv
hw/analog_top.sv
tb/analog_assert.sv
tb/analog_tb.sv

//--- tb/analog_golden.txt
// mode loop | adc_cal g0 o0 g1 o1 | dac_cal g0 o0 g1 o1 | adc0 adc1 | gen0 gen1 | exp_adc0 exp_adc1 | exp_dac0 exp_dac1
// mode 0 holds 6 cycles then checks, mode 1 streams checked 3 cycles later with one config and loop off
0 0 4000 0000 4000 0000 4000 0000 4000 0000 0000 3FFF 0000 0000 1FFF 2000 1FFF 1FFF
0 0 4000 0000 4000 0000 4000 0000 4000 0000 1FFF 2000 0001 3FFF 0000 3FFF 1FFE 2000
0 0 2000 0064 6000 3F00 4000 0000 4000 0000 1C17 376F 0000 0000 0258 2000 1FFF 1FFF
0 0 7FFF 0100 C000 0010 4000 0000 4000 0000 088F 1F37 1000 3000 1FFF 3F48 0FFF 2FFF
0 0 4000 0000 4000 0000 2000 0032 4000 3F9C 1FFF 1FFF 0400 3C00 0000 0000 1DCD 2463
0 0 4000 0000 4000 0000 4000 0FA0 8000 0000 1FFF 1FFF 1388 1000 0000 0000 0000 3FFF
0 1 2000 0010 4000 3FF0 4000 0064 2000 0000 1234 0ABC 07D0 3830 042A 3C08 17CB 23E7
0 1 7FFF 1000 4000 2000 4000 0000 4000 0000 0000 3FFF 1388 3C18 1FFF 2000 0C77 23E7
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 0000 1FFF 0000 0000 1FFF 0008 1FFF 2001
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 1FFF 0FFF 0100 0005 0000 0808 1EFF 1FFC
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 3FFF 2000 3FFF 2000 2000 0007 2000 3FFF
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 1C17 376F 1FFF 1FFF 03E8 3450 0000 0002
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 0001 0001 0ABC 3F00 1FFE 1007 1543 2101
1 0 4000 0000 2000 0008 4000 0000 4000 3FFE 2000 3000 2000 0002 3FFF 3807 3FFF 1FFF
0 0 4000 0000 4000 0000 4000 0000 4000 0000 088F 1F37 1770 00C8 1770 00C8 088F 1F37
